// File: hw/lsu_defs.svh
// LSU sizing macros
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Store buffer depth
// Only depth-1 entries are ever held since full is raised one early
`define ST_BUF_NUM_ENTRIES 8

// Data RAM depth in 64-bit words
`define DMEM_WORDS 512

// Top address bit used by the load/store collision compare
// Covers the whole 4 KiB byte range of the RAM
`define CMP_ADDR_MSB 11

`endif

// File: hw/lsu_pkg.sv
// LSU shared types
package lsu_pkg;

    // Access width as log2 of the byte count
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'd0,  // 1 byte
        MEM_HALF   = 2'd1,  // 2 bytes
        MEM_WORD   = 2'd2,  // 4 bytes
        MEM_DOUBLE = 2'd3   // 8 bytes
    } mem_size_t;

    // One buffered store
    typedef struct packed {
        logic [63:0] addr;  // Byte address
        logic [63:0] data;  // Store value, right aligned
        mem_size_t   size;  // Access width
    } store_entry_t;

    // One pending load
    typedef struct packed {
        logic [63:0] addr;  // Byte address
        mem_size_t   size;  // Access width
        logic        sign;  // Sign-extend the result
    } load_req_t;

endpackage

// File: hw/store_buffer.sv
// Store buffer queue
`timescale 1ns/1ps
`include "lsu_defs.svh"

module store_buffer import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         flush_i,         // Drop all undrained stores
    input  logic         write_en_i,      // New store at the tail
    input  store_entry_t entry_i,
    input  logic         advance_head_i,  // Retire the oldest entry
    input  logic [63:0]  chk_addr_i,      // Address of the pending load
    input  mem_size_t    chk_size_i,
    output store_entry_t head_entry_o,
    output logic         head_valid_o,
    output logic         empty_o,
    output logic         full_o,
    output logic         collision_o      // Load overlaps a buffered store
);

    localparam int NUM   = `ST_BUF_NUM_ENTRIES;
    localparam int PTR_W = $clog2(NUM);

    logic [PTR_W-1:0] head;  // Oldest entry
    logic [PTR_W-1:0] tail;  // Next free slot
    logic [PTR_W:0]   num;   // One bit wider than the pointers

    logic write_ok;
    logic advance_ok;

    store_entry_t    entry_table [NUM];
    logic [NUM-1:0]  valid_table;

    // Capacity is one below depth, a store seen with full high is dropped
    assign write_ok   = write_en_i & (num < NUM - 1);
    assign advance_ok = advance_head_i & (num != '0);  // Ignore retire when empty

    // Entry payload written at the tail
    always_ff @(posedge clk_i) begin
        if (write_ok && !flush_i) begin
            entry_table[tail] <= entry_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_table <= '0;
        end else if (flush_i) begin
            valid_table <= '0;  // Everything not yet drained is lost
        end else begin
            if (write_ok) begin
                valid_table[tail] <= 1'b1;
            end
            if (advance_ok) begin
                valid_table[head] <= 1'b0;
            end
        end
    end

    // Pointers wrap at NUM so odd depths work too
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head <= '0;
            tail <= '0;
            num  <= '0;
        end else if (flush_i) begin
            head <= '0;
            tail <= '0;
            num  <= '0;
        end else begin
            if (advance_ok) begin
                head <= (head == PTR_W'(NUM - 1)) ? '0 : head + 1'b1;
            end
            if (write_ok) begin
                tail <= (tail == PTR_W'(NUM - 1)) ? '0 : tail + 1'b1;
            end
            num <= num + (PTR_W + 1)'(write_ok) - (PTR_W + 1)'(advance_ok);
        end
    end

    // Coarse overlap test, widest of the two sizes sets the ignored low bits
    always_comb begin : collision_detector
        logic [1:0] k;
        logic       hit;
        collision_o = 1'b0;
        for (int j = 0; j < NUM; j++) begin
            k   = (chk_size_i > entry_table[j].size) ? chk_size_i : entry_table[j].size;
            hit = 1'b1;
            for (int i = 0; i <= `CMP_ADDR_MSB; i++) begin
                if (i >= int'(k) && entry_table[j].addr[i] != chk_addr_i[i]) begin
                    hit = 1'b0;  // Differs above the size boundary
                end
            end
            collision_o = collision_o | (valid_table[j] & hit);
        end
    end

    assign head_valid_o = (num != '0);
    assign head_entry_o = head_valid_o ? entry_table[head] : '0;

    assign empty_o = (num == '0);
    // Raised one entry early, and while flushing or in reset
    assign full_o  = (num >= (NUM - 1)) | flush_i | ~rstn_i;

endmodule

// File: hw/store_drain.sv
// Store drain engine
`timescale 1ns/1ps
`include "lsu_defs.svh"

module store_drain import lsu_pkg::*; #(
    localparam int AW = $clog2(`DMEM_WORDS)  // Word index width
) (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          drain_en_i,      // Commit permission level
    input  store_entry_t  head_entry_i,
    input  logic          head_valid_i,
    output logic          ram_we_o,
    output logic [AW-1:0] ram_waddr_o,
    output logic [7:0]    ram_be_o,
    output logic [63:0]   ram_wdata_o,
    output logic          advance_head_o   // Retire head on the write edge
);

    logic [7:0]  lane_base;   // Mask before shifting to the byte offset
    logic [2:0]  byte_off;

    assign byte_off = head_entry_i.addr[2:0];

    always_comb begin
        case (head_entry_i.size)
            MEM_BYTE: lane_base = 8'h01;
            MEM_HALF: lane_base = 8'h03;
            MEM_WORD: lane_base = 8'h0f;
            default:  lane_base = 8'hff;  // Double
        endcase
    end

    // One store per cycle when allowed
    assign ram_we_o       = drain_en_i & head_valid_i;
    assign advance_head_o = ram_we_o;

    assign ram_waddr_o = head_entry_i.addr[AW+2:3];
    assign ram_be_o    = lane_base << byte_off;
    assign ram_wdata_o = head_entry_i.data << {byte_off, 3'b000};  // Into lane position

endmodule

// File: hw/data_ram.sv
// Byte-enabled data RAM
`timescale 1ns/1ps
`include "lsu_defs.svh"

module data_ram #(
    localparam int AW = $clog2(`DMEM_WORDS)
) (
    input  logic          clk_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  logic [7:0]    be_i,     // One enable per byte lane
    input  logic [63:0]   wdata_i,
    input  logic          re_i,
    input  logic [AW-1:0] raddr_i,
    output logic [63:0]   rdata_o   // Valid the cycle after re_i
);

    logic [63:0] mem [`DMEM_WORDS];

    // Memory starts cleared
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Same-word write and read returns old data
    always @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 8; b++) begin
                if (be_i[b]) begin
                    mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: hw/load_unit.sv
// Load unit
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_unit import lsu_pkg::*; #(
    localparam int AW = $clog2(`DMEM_WORDS)
) (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          load_valid_i,
    input  logic [63:0]   load_addr_i,
    input  mem_size_t     load_size_i,
    input  logic          load_signed_i,
    input  logic          collision_i,   // From the store buffer, same cycle
    input  logic [63:0]   ram_rdata_i,
    output logic [63:0]   chk_addr_o,
    output mem_size_t     chk_size_o,
    output logic          ram_re_o,
    output logic [AW-1:0] ram_raddr_o,
    output logic          busy_o,
    output logic          done_o,        // One-cycle pulse with data_o
    output logic [63:0]   data_o
);

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT,   // Request held until no store overlaps
        LD_READ    // RAM data arrives this cycle
    } ld_state_t;

    ld_state_t   state_q;
    load_req_t   req_q;
    logic [63:0] shifted;
    logic [63:0] result;

    assign busy_o      = (state_q != LD_IDLE);
    assign chk_addr_o  = req_q.addr;
    assign chk_size_o  = req_q.size;
    assign ram_re_o    = (state_q == LD_WAIT) & ~collision_i;
    assign ram_raddr_o = req_q.addr[AW+2:3];

    // Field down to bit 0 then extend
    assign shifted = ram_rdata_i >> {req_q.addr[2:0], 3'b000};

    always_comb begin
        case (req_q.size)
            MEM_BYTE: result = {{56{req_q.sign & shifted[7]}}, shifted[7:0]};
            MEM_HALF: result = {{48{req_q.sign & shifted[15]}}, shifted[15:0]};
            MEM_WORD: result = {{32{req_q.sign & shifted[31]}}, shifted[31:0]};
            default:  result = shifted;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= LD_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                LD_IDLE: if (load_valid_i) state_q <= LD_WAIT;
                LD_WAIT: if (!collision_i) state_q <= LD_READ;  // Read issued now
                LD_READ: begin
                    state_q <= LD_IDLE;
                    done_o  <= 1'b1;
                end
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (state_q == LD_IDLE && load_valid_i) begin
            req_q <= '{addr: load_addr_i, size: load_size_i, sign: load_signed_i};
        end
        if (state_q == LD_READ) begin
            data_o <= result;
        end
    end

endmodule

// File: hw/lsu_top.sv
// LSU top level
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    // Store side
    input  logic        store_valid_i,
    input  logic [63:0] store_addr_i,
    input  logic [63:0] store_data_i,
    input  mem_size_t   store_size_i,
    input  logic        drain_en_i,     // Commit permission
    input  logic        flush_i,
    // Load side
    input  logic        load_valid_i,
    input  logic [63:0] load_addr_i,
    input  mem_size_t   load_size_i,
    input  logic        load_signed_i,
    output logic        load_busy_o,
    output logic        load_done_o,
    output logic [63:0] load_data_o,
    // Status
    output logic        sb_empty_o,
    output logic        sb_full_o
);

    store_entry_t head_entry;
    logic         head_valid;
    logic         advance_head;
    logic [63:0]  chk_addr;
    mem_size_t    chk_size;
    logic         collision;

    logic         ram_we;
    logic [8:0]   ram_waddr;   // Word index for 512 words
    logic [7:0]   ram_be;
    logic [63:0]  ram_wdata;
    logic         ram_re;
    logic [8:0]   ram_raddr;
    logic [63:0]  ram_rdata;

    store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .write_en_i     (store_valid_i),
        .entry_i        ({store_addr_i, store_data_i, store_size_i}),
        .advance_head_i (advance_head),
        .chk_addr_i     (chk_addr),
        .chk_size_i     (chk_size),
        .head_entry_o   (head_entry),
        .head_valid_o   (head_valid),
        .empty_o        (sb_empty_o),
        .full_o         (sb_full_o),
        .collision_o    (collision)
    );

    store_drain u_store_drain (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .drain_en_i     (drain_en_i),
        .head_entry_i   (head_entry),
        .head_valid_i   (head_valid),
        .ram_we_o       (ram_we),
        .ram_waddr_o    (ram_waddr),
        .ram_be_o       (ram_be),
        .ram_wdata_o    (ram_wdata),
        .advance_head_o (advance_head)
    );

    data_ram u_data_ram (
        .clk_i   (clk_i),
        .we_i    (ram_we),
        .waddr_i (ram_waddr),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .re_i    (ram_re),
        .raddr_i (ram_raddr),
        .rdata_o (ram_rdata)
    );

    load_unit u_load_unit (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .load_valid_i  (load_valid_i),
        .load_addr_i   (load_addr_i),
        .load_size_i   (load_size_i),
        .load_signed_i (load_signed_i),
        .collision_i   (collision),
        .ram_rdata_i   (ram_rdata),
        .chk_addr_o    (chk_addr),
        .chk_size_o    (chk_size),
        .ram_re_o      (ram_re),
        .ram_raddr_o   (ram_raddr),
        .busy_o        (load_busy_o),
        .done_o        (load_done_o),
        .data_o        (load_data_o)
    );

endmodule

// File: testbench/lsu_tb.sv
// LSU testbench
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int K_STORE     = 0;
    localparam int K_LOAD      = 1;
    localparam int K_DRAIN     = 2;   // Data column holds the drain level
    localparam int K_FLUSH     = 3;
    localparam int K_STATUS    = 4;   // Expected column holds {full, empty}
    localparam int DRAIN_LIMIT = 32;  // Cycles allowed for the buffer to empty
    localparam int LOAD_LIMIT  = 48;  // Cycles allowed for load_done
    localparam int NSB         = `ST_BUF_NUM_ENTRIES;

    logic        clk;
    logic        rstn;
    logic        store_valid;
    logic [63:0] store_addr;
    logic [63:0] store_data;
    mem_size_t   store_size;
    logic        drain_en;
    logic        flush;
    logic        load_valid;
    logic [63:0] load_addr;
    mem_size_t   load_size;
    logic        load_signed;
    logic        load_busy;
    logic        load_done;
    logic [63:0] load_data;
    logic        sb_empty;
    logic        sb_full;

    // Step table, one entry per index across all queues
    string       name_q[$];
    int          kind_q[$];
    logic [63:0] addr_q[$];
    mem_size_t   size_q[$];
    bit          sign_q[$];
    logic [63:0] data_q[$];     // Forced store bits, hold cycles or drain level
    logic [63:0] exp_q[$];
    bit          has_exp_q[$];  // Table value to cross-check against the model

    logic [7:0]  model_mem [4096];  // Byte image of the RAM after drained stores
    logic [63:0] pend_addr[$];      // Accepted stores not yet in the model
    logic [63:0] pend_data[$];
    mem_size_t   pend_size[$];

    integer seed = 32'h484d2f7a;
    bit     table_ready = 1'b0;
    int     step_err;
    int     pass_cnt = 0;
    int     fail_cnt = 0;

    lsu_top UUT (
        .clk_i (clk), .rstn_i (rstn),
        .store_valid_i (store_valid), .store_addr_i (store_addr),
        .store_data_i (store_data), .store_size_i (store_size),
        .drain_en_i (drain_en), .flush_i (flush),
        .load_valid_i (load_valid), .load_addr_i (load_addr),
        .load_size_i (load_size), .load_signed_i (load_signed),
        .load_busy_o (load_busy), .load_done_o (load_done), .load_data_o (load_data),
        .sb_empty_o (sb_empty), .sb_full_o (sb_full)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    task automatic add_step(input string nm, input int kd, input logic [63:0] ad,
                            input mem_size_t sz, input bit sg, input logic [63:0] dt,
                            input logic [63:0] ex, input bit he);
        name_q.push_back(nm);
        kind_q.push_back(kd);
        addr_q.push_back(ad);
        size_q.push_back(sz);
        sign_q.push_back(sg);
        data_q.push_back(dt);
        exp_q.push_back(ex);
        has_exp_q.push_back(he);
    endtask

    // Little-endian read of the byte image, then extension
    function automatic logic [63:0] model_load(input logic [63:0] ad, input mem_size_t sz,
                                               input bit sg);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << sz;
        for (int i = 0; i < n; i++) v[i*8 +: 8] = model_mem[ad[11:0] + i];
        for (int i = 8; i < 64; i++) begin
            if (i >= n * 8) v[i] = sg & v[n*8-1];
        end
        return v;
    endfunction

    task automatic apply_pending();
        while (pend_addr.size() > 0) begin
            for (int i = 0; i < (1 << pend_size[0]); i++) begin
                model_mem[pend_addr[0][11:0] + i] = pend_data[0][i*8 +: 8];
            end
            void'(pend_addr.pop_front());
            void'(pend_data.pop_front());
            void'(pend_size.pop_front());
        end
    endtask

    // Buffer empty with drain on means every accepted store reached the RAM
    task automatic wait_drained();
        bit empty;
        empty = 1'b0;
        for (int c = 0; c < DRAIN_LIMIT && !empty; c++) begin
            @(negedge clk);
            empty = sb_empty;
        end
        assert (empty) else begin
            $display("Store buffer did not drain within %0d cycles", DRAIN_LIMIT);
            step_err++;
        end
        apply_pending();
    endtask

    task automatic run_store(input int s);
        logic [63:0] dt;
        bit          accepted;
        dt = {$random(seed), $random(seed)} | data_q[s];
        @(posedge clk);
        store_valid <= 1'b1;
        store_addr  <= addr_q[s];
        store_data  <= dt;
        store_size  <= size_q[s];
        @(negedge clk);
        accepted = !sb_full;  // Value seen by the accepting edge
        @(posedge clk);
        store_valid <= 1'b0;
        assert (accepted == exp_q[s][0]) else begin
            $display("Mismatch %s: expected accept %0d, actual %0d", name_q[s], exp_q[s][0],
                     accepted);
            step_err++;
        end
        // Model follows the table, a dropped store never reaches it
        if (exp_q[s][0]) begin
            pend_addr.push_back(addr_q[s]);
            pend_data.push_back(dt);
            pend_size.push_back(size_q[s]);
        end
    endtask

    task automatic run_load(input int s);
        logic [63:0] want;
        logic [63:0] got;
        bit          done;
        @(posedge clk);
        load_valid  <= 1'b1;
        load_addr   <= addr_q[s];
        load_size   <= size_q[s];
        load_signed <= sign_q[s];
        @(posedge clk);
        load_valid <= 1'b0;
        // Held load must stay busy while the overlapping store waits
        for (int c = 0; c < data_q[s]; c++) begin
            @(negedge clk);
            assert (load_busy && !load_done) else begin
                $display("Load %s finished while an overlapping store was buffered", name_q[s]);
                step_err++;
            end
        end
        if (data_q[s] != 0) begin
            @(posedge clk);
            drain_en <= 1'b1;  // Release the blocking store
        end
        done = 1'b0;
        got  = '0;
        for (int c = 0; c < LOAD_LIMIT && !done; c++) begin
            @(negedge clk);
            done = load_done;
            got  = load_data;
        end
        assert (done) else begin
            $display("Timeout: load %s never completed", name_q[s]);
            step_err++;
        end
        if (data_q[s] != 0) wait_drained();
        want = model_load(addr_q[s], size_q[s], sign_q[s]);
        if (has_exp_q[s]) begin
            assert (exp_q[s] == want) else begin
                $display("Mismatch %s: expected %h, actual %h (table vs model)", name_q[s],
                         exp_q[s], want);
                step_err++;
            end
        end
        if (done) begin
            assert (got == want) else begin
                $display("Mismatch %s: expected %h, actual %h", name_q[s], want, got);
                step_err++;
            end
        end
    endtask

    task automatic run_control(input int s);
        logic [1:0] got;
        case (kind_q[s])
            K_DRAIN: begin
                @(posedge clk);
                drain_en <= data_q[s][0];
                if (data_q[s][0]) wait_drained();
            end
            K_FLUSH: begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                pend_addr.delete();  // Undrained stores are gone
                pend_data.delete();
                pend_size.delete();
            end
            default: begin
                @(posedge clk);
                @(negedge clk);
                got = {sb_full, sb_empty};
                assert (got == exp_q[s][1:0]) else begin
                    $display("Mismatch %s: expected full/empty %b, actual %b", name_q[s],
                             exp_q[s][1:0], got);
                    step_err++;
                end
            end
        endcase
    endtask

    // Run budget scales with the table length
    initial begin
        wait (table_ready);
        repeat (16 + name_q.size() * 64) @(posedge clk);
        $display("Watchdog expired before the step table finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rstn        = 1'b0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        store_size  = MEM_BYTE;
        drain_en    = 1'b0;
        flush       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_size   = MEM_BYTE;
        load_signed = 1'b0;
        for (int i = 0; i < 4096; i++) model_mem[i] = 8'h00;

        // Store then load of every size
        add_step("drain_on",     K_DRAIN,  64'h000, MEM_BYTE,   0, 64'h1,         0, 0);
        add_step("st_double",    K_STORE,  64'h000, MEM_DOUBLE, 0, 64'h0,         1, 1);
        add_step("st_word",      K_STORE,  64'h00c, MEM_WORD,   0, 64'h8000_0000, 1, 1);
        add_step("st_byte",      K_STORE,  64'h013, MEM_BYTE,   0, 64'h80,        1, 1);
        add_step("drain_wait",   K_DRAIN,  64'h000, MEM_BYTE,   0, 64'h1,         0, 0);
        add_step("ld_double",    K_LOAD,   64'h000, MEM_DOUBLE, 0, 64'h0,         0, 0);
        add_step("ld_word_s",    K_LOAD,   64'h00c, MEM_WORD,   1, 64'h0,         0, 0);
        add_step("ld_word_u",    K_LOAD,   64'h00c, MEM_WORD,   0, 64'h0,         0, 0);
        add_step("ld_half_s",    K_LOAD,   64'h00e, MEM_HALF,   1, 64'h0,         0, 0);
        add_step("ld_half_u",    K_LOAD,   64'h00e, MEM_HALF,   0, 64'h0,         0, 0);
        add_step("ld_byte_s",    K_LOAD,   64'h013, MEM_BYTE,   1, 64'h0,         0, 0);
        add_step("ld_byte_u",    K_LOAD,   64'h013, MEM_BYTE,   0, 64'h0,         0, 0);
        // Byte-lane merge inside one double word
        add_step("mg_double",    K_STORE,  64'h040, MEM_DOUBLE, 0, 64'h0,         1, 1);
        add_step("mg_half_a",    K_STORE,  64'h042, MEM_HALF,   0, 64'h0,         1, 1);
        add_step("mg_half_b",    K_STORE,  64'h046, MEM_HALF,   0, 64'h0,         1, 1);
        add_step("mg_byte",      K_STORE,  64'h045, MEM_BYTE,   0, 64'h0,         1, 1);
        add_step("mg_drain",     K_DRAIN,  64'h000, MEM_BYTE,   0, 64'h1,         0, 0);
        add_step("mg_ld_double", K_LOAD,   64'h040, MEM_DOUBLE, 0, 64'h0,         0, 0);
        // Load held behind an overlapping store, 20 cycles
        add_step("col_drain_off", K_DRAIN, 64'h000, MEM_BYTE,   0, 64'h0,         0, 0);
        add_step("col_st_word",  K_STORE,  64'h080, MEM_WORD,   0, 64'h0,         1, 1);
        add_step("col_ld_byte",  K_LOAD,   64'h081, MEM_BYTE,   0, 64'd20,        0, 0);
        // Store in another 16-byte block does not hold the load
        add_step("nc_drain_off", K_DRAIN,  64'h000, MEM_BYTE,   0, 64'h0,         0, 0);
        add_step("nc_st_double", K_STORE,  64'h000, MEM_DOUBLE, 0, 64'h0,         1, 1);
        add_step("nc_ld_double", K_LOAD,   64'h010, MEM_DOUBLE, 0, 64'h0,         0, 0);
        add_step("nc_status",    K_STATUS, 64'h000, MEM_BYTE,   0, 64'h0,         0, 1);
        // Flush discards both held stores
        add_step("fl_st_word",   K_STORE,  64'h00c, MEM_WORD,   0, 64'h0,         1, 1);
        add_step("fl_flush",     K_FLUSH,  64'h000, MEM_BYTE,   0, 64'h0,         0, 0);
        add_step("fl_status",    K_STATUS, 64'h000, MEM_BYTE,   0, 64'h0,         1, 1);
        add_step("fl_ld_double", K_LOAD,   64'h000, MEM_DOUBLE, 0, 64'h0,         0, 0);
        add_step("fl_ld_word",   K_LOAD,   64'h00c, MEM_WORD,   1, 64'h0,         0, 0);
        // Buffer holds depth-1 stores, the next one is dropped
        for (int i = 0; i < NSB - 1; i++) begin
            add_step($sformatf("full_st%0d", i), K_STORE, 64'h200 + 8 * i, MEM_DOUBLE, 0,
                     64'h0, 1, 1);
        end
        add_step("full_status",  K_STATUS, 64'h000, MEM_BYTE,   0, 64'h0,         2, 1);
        add_step("full_st_drop", K_STORE,  64'h200 + 8 * (NSB - 1), MEM_DOUBLE, 0, 0, 0, 1);
        add_step("full_drain",   K_DRAIN,  64'h000, MEM_BYTE,   0, 64'h1,         0, 0);
        add_step("full_ld_drop", K_LOAD,   64'h200 + 8 * (NSB - 1), MEM_DOUBLE, 0, 0, 0, 1);
        add_step("full_ld_last", K_LOAD,   64'h200 + 8 * (NSB - 2), MEM_DOUBLE, 0, 0, 0, 0);
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        for (int s = 0; s < name_q.size(); s++) begin
            step_err = 0;
            if (kind_q[s] == K_STORE) run_store(s);
            else if (kind_q[s] == K_LOAD) run_load(s);
            else run_control(s);
            if (step_err == 0) begin
                pass_cnt++;
                $display("%-14s ok", name_q[s]);
            end else begin
                fail_cnt++;
                $display("%-14s failed", name_q[s]);
            end
        end

        $display("Steps: %0d run, %0d passed, %0d failed", name_q.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: lsu_top.f
+incdir+hw
hw/lsu_pkg.sv
hw/store_buffer.sv
hw/store_drain.sv
hw/data_ram.sv
hw/load_unit.sv
hw/lsu_top.sv
testbench/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f lsu_top.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/lsu_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
else
    exit 1
fi
